// ==== Makefile ====
# Verilator build and run of the platform testbench.
# Any variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= platformTb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  ?= Test FAILED
PASS_MSG  ?= Test OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/interruptCtrl_asserts.sv ====
// ====================================================================
// Interrupt controller assertions.
// Checks the request level, the claim identifier and the reset state.
// ====================================================================

`timescale 1ns/100ps

module interruptCtrl_asserts import platformPkg::*; (
    input logic   clk,
    input logic   rst,
    input irqVecT irqEnable,
    input irqVecT irqPending,
    input irqIdT  claimId,
    input logic   irq
);

    int failCount = 0;                              // Number of failed assertions.

    irqMasked: assert property (@(posedge clk) disable iff (rst)
        irq == |(irqPending & irqEnable))
        else begin
            $error("irq differs from pending masked by enable");
            failCount++;
        end

    // A claim may only name a source that is both pending and enabled.
    claimLegal: assert property (@(posedge clk) disable iff (rst)
        (claimId == ID_NONE)
        || (claimId == ID_BUTTON && irqPending[SRC_BUTTON] && irqEnable[SRC_BUTTON])
        || (claimId == ID_TIMER && irqPending[SRC_TIMER] && irqEnable[SRC_TIMER]))
        else begin
            $error("claimId names a source that is not pending and enabled");
            failCount++;
        end

    resetClear: assert property (@(posedge clk) rst |=> (irqPending == '0))
        else begin
            $error("pending bits set while in reset");
            failCount++;
        end

endmodule

bind interruptCtrl interruptCtrl_asserts irqAsserts_i (
    .clk        (clk),
    .rst        (rst),
    .irqEnable  (irqEnable),
    .irqPending (irqPending),
    .claimId    (claimId),
    .irq        (irq)
);

// ==== dv/platformClkGen.sv ====
// ====================================================================
// Testbench clock and reset.
// 10 ns clock and a synchronous reset held for three cycles.
// ====================================================================

`timescale 1ns/100ps

module platformClkGen (
    output logic clk,
    output logic rst
);

    localparam int RESET_CYCLES = 3;                // Cycles with rst held high.

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;                      // Half of the 10 ns period.
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;                                // Released on a rising edge.
    end

endmodule

// ==== dv/platformTb.sv ====
// ====================================================================
// Platform testbench.
// Stands in for the core on the data bus, bounces the button and checks
// every read response and the irq line against a shadow model.
// ====================================================================

`timescale 1ns/100ps

module platformTb import platformPkg::*; ();

    localparam int SEED       = 40502;
    localparam int MAX_CYCLES = 4000;               // About three times the longest run.
    localparam int PRESS_LAT  = 2 + DEBOUNCE_CYCLES + 1; // BTND high to press strobe.

    logic   clk;
    logic   rst;
    logic   BTND;
    logic   accEn;
    logic   accWe;
    addrT   accAddr;
    dataT   accWdata;
    logic   rdValid;
    dataT   rdData;
    logic   irq;

    timeT   shTime;                                 // Shadow of the machine time.
    timeT   shCmp;
    irqVecT shEn;
    irqVecT shPend;
    int     highRun;                                // Cycles BTND has been sampled high.
    logic   readIssued;                             // A read was strobed at the last edge.
    dataT   expQ[$];                                // Expected words of outstanding reads.
    int     errCount   = 0;
    int     errAtStart = 0;
    int     testCount  = 0;
    int     testFails  = 0;
    int     cycleCnt   = 0;

    platformClkGen clkGen_i (.clk(clk), .rst(rst));

    fpgaPlatform dut_i (
        .clk      (clk),
        .rst      (rst),
        .BTND     (BTND),
        .accEn    (accEn),
        .accWe    (accWe),
        .accAddr  (accAddr),
        .accWdata (accWdata),
        .rdValid  (rdValid),
        .rdData   (rdData),
        .irq      (irq)
    );

    // ====================================================================
    // Reference model
    // ====================================================================
    function automatic irqIdT expectClaim(input irqVecT active);
        if (active[SRC_BUTTON]) return ID_BUTTON;   // Lowest source number ranks first.
        if (active[SRC_TIMER]) return ID_TIMER;
        return ID_NONE;
    endfunction

    function automatic dataT refRead(input addrT addr);
        case ({addr[15:2], 2'b00})
            ADDR_MTIME_LO:    return shTime[31:0];
            ADDR_MTIME_HI:    return shTime[63:32];
            ADDR_MTIMECMP_LO: return shCmp[31:0];
            ADDR_MTIMECMP_HI: return shCmp[63:32];
            ADDR_IRQ_ENABLE:  return dataT'(shEn);
            ADDR_IRQ_PENDING: return dataT'(shPend);
            ADDR_IRQ_CLAIM:   return dataT'(expectClaim(shPend & shEn));
            default:          return '0;
        endcase
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            shTime     <= '0;
            shCmp      <= MTIMECMP_RESET;
            shEn       <= '0;
            shPend     <= '0;
            highRun    <= 0;
            readIssued <= 1'b0;
        end else begin
            shTime            <= shTime + 64'd1;
            readIssued        <= accEn && !accWe;
            shPend[SRC_TIMER] <= (shTime >= shCmp); // Timer bit lags the compare by a cycle.
            if (accEn && accWe) begin
                case ({accAddr[15:2], 2'b00})
                    ADDR_MTIMECMP_LO: shCmp[31:0]  <= accWdata;
                    ADDR_MTIMECMP_HI: shCmp[63:32] <= accWdata;
                    ADDR_IRQ_ENABLE:  shEn         <= accWdata[1:0];
                    ADDR_IRQ_PENDING: begin
                        if (accWdata[SRC_BUTTON]) begin
                            shPend[SRC_BUTTON] <= 1'b0;
                        end
                    end
                    default: ;
                endcase
            end
            if (highRun == PRESS_LAT) begin
                shPend[SRC_BUTTON] <= 1'b1;         // Press wins over a clear.
            end
            if (!BTND) begin
                highRun <= 0;
            end else if (highRun <= PRESS_LAT) begin
                highRun <= highRun + 1;
            end
        end
    end

    // ====================================================================
    // Checks, compare process and timeout
    // ====================================================================
    task automatic checkValue(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
        if (got !== exp) begin
            errCount++;
            $display("[FAIL] %0t ns %s: got %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            checkValue("rdValid", rdValid, readIssued);
            if (readIssued) begin
                if (expQ.size() == 0) begin
                    errCount++;
                    $display("Read response at %0t ns had no expected word queued", $time);
                end else begin
                    checkValue("rdData", rdData, expQ.pop_front());
                end
            end
            checkValue("irq", irq, |(shPend & shEn));
        end
    end

    always @(posedge clk) begin
        cycleCnt <= cycleCnt + 1;
        if (cycleCnt >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    // ====================================================================
    // Bus tasks
    // ====================================================================
    task automatic busWrite(input addrT addr, input dataT data);
        accEn    = 1'b1;
        accWe    = 1'b1;
        accAddr  = addr;
        accWdata = data;
        @(negedge clk);
        accEn = 1'b0;
    endtask

    task automatic busRead(input addrT addr, output dataT data);
        accEn   = 1'b1;
        accWe   = 1'b0;
        accAddr = addr;
        expQ.push_back(refRead(addr));              // Word as held at the strobe edge.
        @(negedge clk);
        accEn = 1'b0;
        data  = rdData;                             // Valid one cycle after the strobe.
    endtask

    task automatic waitCycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic waitIrq(input logic level, input int limit);
        int n = 0;
        while (irq !== level && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (irq !== level) begin
            errCount++;
            $display("irq did not reach %0b within %0d cycles at %0t ns", level, limit, $time);
        end
    endtask

    task automatic waitPending(input irqVecT want, input int limit);
        dataT rd;
        int   n = 0;
        do begin
            busRead(ADDR_IRQ_PENDING, rd);
            n++;
        end while ((irqVecT'(rd) & want) != want && n < limit);
        if ((irqVecT'(rd) & want) != want) begin
            errCount++;
            $display("Pending bits %0b never set within %0d reads at %0t ns", want, limit, $time);
        end
    endtask

    task automatic finishTest(input string name);
        testCount++;
        if (errCount != errAtStart) begin
            testFails++;
        end
        $display("%0t ns %s finished with %0d errors", $time, name, errCount - errAtStart);
        errAtStart = errCount;
    endtask

    // ====================================================================
    // Stimulus
    // ====================================================================
    initial begin
        dataT   rd;
        dataT   prev;
        timeT   target;
        irqVecT mask;
        int     assertFails;
        int     relCycle;                           // Cycle count when reset was released.
        BTND     = 1'b0;
        accEn    = 1'b0;
        accWe    = 1'b0;
        accAddr  = '0;
        accWdata = '0;
        void'($urandom(SEED));
        do @(negedge clk); while (rst);
        relCycle = cycleCnt;

        for (int a = 0; a <= 32; a += 4) begin      // Whole map plus two unmapped words.
            busRead(addrT'(a), rd);
        end
        busRead(16'h0103, rd);
        checkValue("unmapped read", rd, 0);
        checkValue("irq after reset", irq, 0);
        finishTest("reset values");

        busRead(ADDR_MTIME_LO, prev);
        repeat (4) begin
            waitCycles($urandom_range(0, 5));
            busRead(ADDR_MTIME_LO, rd);
            checkValue("mtime increases", rd > prev, 1);
            checkValue("mtime within elapsed cycles", rd <= cycleCnt - relCycle, 1);
            prev = rd;
        end
        repeat (4) begin
            target = {$urandom, $urandom};
            busWrite(ADDR_MTIMECMP_LO, target[31:0]);
            busWrite(ADDR_MTIMECMP_HI, target[63:32]);
            busRead(ADDR_MTIMECMP_LO, rd);
            checkValue("mtimeCmp low", rd, target[31:0]);
            busRead(ADDR_MTIMECMP_HI, rd);
            checkValue("mtimeCmp high", rd, target[63:32]);
        end
        finishTest("time and compare");

        busRead(ADDR_MTIME_LO, rd);
        target = timeT'(rd) + 64'd300;              // A few hundred cycles ahead.
        busWrite(ADDR_MTIMECMP_HI, '1);
        busWrite(ADDR_MTIMECMP_LO, target[31:0]);
        busWrite(ADDR_MTIMECMP_HI, target[63:32]);
        busWrite(ADDR_IRQ_ENABLE, 32'h2);
        checkValue("irq before compare", irq, 0);
        waitIrq(1'b1, 600);
        busRead(ADDR_MTIME_LO, rd);
        checkValue("mtime past compare", rd >= target[31:0], 1);
        busRead(ADDR_IRQ_CLAIM, rd);
        checkValue("claimId for timer", rd, ID_TIMER);
        busWrite(ADDR_IRQ_PENDING, 32'h2);          // Timer bit ignores the clear.
        busRead(ADDR_IRQ_PENDING, rd);
        checkValue("timer pending after clear", rd[SRC_TIMER], 1);
        busWrite(ADDR_MTIMECMP_HI, 32'h1);
        waitIrq(1'b0, 10);
        finishTest("timer interrupt");

        busWrite(ADDR_IRQ_ENABLE, 32'h1);
        for (int i = 0; i < 6; i++) begin
            BTND = ~BTND;                           // Bounce starts high and ends low.
            waitCycles($urandom_range(1, DEBOUNCE_CYCLES - 4));
        end
        busRead(ADDR_IRQ_PENDING, rd);
        checkValue("pending during bounce", rd[SRC_BUTTON], 0);
        BTND = 1'b1;
        waitPending(2'b01, 3 * PRESS_LAT);
        checkValue("irq for button", irq, 1);
        busRead(ADDR_IRQ_CLAIM, rd);
        checkValue("claimId for button", rd, ID_BUTTON);
        busWrite(ADDR_IRQ_PENDING, 32'h1);
        busRead(ADDR_IRQ_PENDING, rd);
        checkValue("pending after clear", rd, 0);
        waitCycles(40);
        busRead(ADDR_IRQ_PENDING, rd);
        checkValue("second press while held", rd[SRC_BUTTON], 0);
        finishTest("button with bounce");

        busWrite(ADDR_MTIMECMP_HI, 32'h0);
        busWrite(ADDR_MTIMECMP_LO, 32'h0);
        BTND = 1'b0;
        waitCycles(DEBOUNCE_CYCLES + 8);            // Long enough for the release to settle.
        BTND = 1'b1;
        waitPending(2'b11, 3 * PRESS_LAT);
        repeat (8) begin
            mask = irqVecT'($urandom);
            busWrite(ADDR_IRQ_ENABLE, dataT'(mask));
            busRead(ADDR_IRQ_CLAIM, rd);
            checkValue("irq for mask", irq, |mask);
            checkValue("claimId for mask", rd, expectClaim(mask));
        end
        repeat (60) begin
            if ($urandom_range(0, 1) == 1) begin
                busWrite(addrT'($urandom_range(0, 9) * 4 + $urandom_range(0, 3)), $urandom);
            end else begin
                busRead(addrT'($urandom_range(0, 9) * 4 + $urandom_range(0, 3)), rd);
            end
        end
        waitCycles(2);
        finishTest("masking and priority");

        assertFails = dut_i.irqCtrl_i.irqAsserts_i.failCount;
        $display("Summary: %0d tests, %0d with errors, %0d check errors, %0d assertion failures",
                 testCount, testFails, errCount, assertFails);
        if (errCount == 0 && assertFails == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== logic/busDecoder.sv ====
// ====================================================================
// Bus decoder.
// Turns an access strobe into block write strobes and returns the
// selected read word one cycle later.
// ====================================================================

`timescale 1ns/100ps

module busDecoder import platformPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   accEn,                           // Single-cycle access strobe.
    input  logic   accWe,                           // High for a write.
    input  addrT   accAddr,
    input  dataT   accWdata,
    input  timeT   mtime,
    input  timeT   mtimeCmp,
    input  irqVecT irqEnable,
    input  irqVecT irqPending,
    input  irqIdT  claimId,
    output logic   timerWrLo,
    output logic   timerWrHi,
    output logic   enWr,
    output logic   pendClr,
    output dataT   wrData,
    output logic   rdValid,
    output dataT   rdData
);

    addrT wordAddr;                                 // Address with the byte bits dropped.
    logic wrEn;
    dataT rdWord;                                   // Selected word before the register.

    assign wordAddr = {accAddr[15:2], 2'b00};
    assign wrEn     = accEn & accWe;

    // ====================================================================
    // Write strobes
    // ====================================================================
    assign timerWrLo = wrEn && (wordAddr == ADDR_MTIMECMP_LO);
    assign timerWrHi = wrEn && (wordAddr == ADDR_MTIMECMP_HI);
    assign enWr      = wrEn && (wordAddr == ADDR_IRQ_ENABLE);
    assign pendClr   = wrEn && (wordAddr == ADDR_IRQ_PENDING);
    assign wrData    = accWdata;                    // Shared by every writable block.

    // ====================================================================
    // Read path
    // ====================================================================
    always_comb begin
        case (wordAddr)
            ADDR_MTIME_LO:    rdWord = mtime[31:0];
            ADDR_MTIME_HI:    rdWord = mtime[63:32];
            ADDR_MTIMECMP_LO: rdWord = mtimeCmp[31:0];
            ADDR_MTIMECMP_HI: rdWord = mtimeCmp[63:32];
            ADDR_IRQ_ENABLE:  rdWord = dataT'(irqEnable);
            ADDR_IRQ_PENDING: rdWord = dataT'(irqPending);
            ADDR_IRQ_CLAIM:   rdWord = dataT'(claimId);
            default:          rdWord = '0;          // Unmapped reads give zero.
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rdValid <= 1'b0;
        end else begin
            rdValid <= accEn & ~accWe;              // Pulses one cycle after a read.
        end
    end

    always_ff @(posedge clk) begin
        if (accEn && !accWe) begin
            rdData <= rdWord;                       // Holds until the next read.
        end
    end

endmodule

// ==== logic/buttonDebounce.sv ====
// ====================================================================
// Button debouncer.
// Synchronizes BTND, waits for a stable level and emits a one-cycle
// press strobe on each accepted press.
// ====================================================================

`timescale 1ns/100ps

module buttonDebounce import platformPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic BTND,                              // Raw button, asynchronous to clk.
    output logic press                              // One cycle per accepted press.
);

    typedef enum logic [1:0] {
        RELEASED,
        CONFIRM_PRESS,
        PRESSED,
        CONFIRM_RELEASE
    } debounceStateT;

    debounceStateT state;
    debounceCntT   stableCnt;                       // Cycles the new level has held.
    logic          btnMeta;                         // First synchronizer stage.
    logic          btnSync;                         // Second stage, safe to use.

    always_ff @(posedge clk) begin
        if (rst) begin
            btnMeta   <= 1'b0;
            btnSync   <= 1'b0;
            state     <= RELEASED;
            stableCnt <= '0;
            press     <= 1'b0;
        end else begin
            btnMeta <= BTND;
            btnSync <= btnMeta;
            press   <= 1'b0;                        // Strobe unless set below.
            case (state)
                RELEASED: begin
                    if (btnSync) begin
                        state     <= CONFIRM_PRESS; // Start timing the new level.
                        stableCnt <= '0;
                    end
                end
                CONFIRM_PRESS: begin
                    if (!btnSync) begin
                        state <= RELEASED;          // Bounce, so fall back.
                    end else if (stableCnt == DEBOUNCE_LAST) begin
                        state <= PRESSED;
                        press <= 1'b1;              // Only this move reports a press.
                    end else begin
                        stableCnt <= stableCnt + 1'b1;
                    end
                end
                PRESSED: begin
                    if (!btnSync) begin
                        state     <= CONFIRM_RELEASE;
                        stableCnt <= '0;
                    end
                end
                CONFIRM_RELEASE: begin
                    if (btnSync) begin
                        state <= PRESSED;           // Release was a glitch.
                    end else if (stableCnt == DEBOUNCE_LAST) begin
                        state <= RELEASED;
                    end else begin
                        stableCnt <= stableCnt + 1'b1;
                    end
                end
                default: state <= RELEASED;
            endcase
        end
    end

endmodule

// ==== logic/fpgaPlatform.sv ====
// ====================================================================
// FPGA platform top.
// Peripheral side of the platform: button debouncer, machine timer,
// interrupt controller and the bus decoder that reaches them.
// ====================================================================

`timescale 1ns/100ps

module fpgaPlatform import platformPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic BTND,                              // Raw push button.
    input  logic accEn,
    input  logic accWe,
    input  addrT accAddr,
    input  dataT accWdata,
    output logic rdValid,
    output dataT rdData,
    output logic irq                                // Interrupt request to the core.
);

    logic   press;                                  // Debounced press strobe.
    logic   timerIrq;
    logic   timerWrLo;
    logic   timerWrHi;
    logic   enWr;
    logic   pendClr;
    dataT   wrData;
    timeT   mtime;
    timeT   mtimeCmp;
    irqVecT irqEnable;
    irqVecT irqPending;
    irqIdT  claimId;

    buttonDebounce debounce_i (
        .clk   (clk),
        .rst   (rst),
        .BTND  (BTND),
        .press (press)
    );

    machineTimer timer_i (
        .clk       (clk),
        .rst       (rst),
        .timerWrLo (timerWrLo),
        .timerWrHi (timerWrHi),
        .wrData    (wrData),
        .mtime     (mtime),
        .mtimeCmp  (mtimeCmp),
        .timerIrq  (timerIrq)
    );

    interruptCtrl irqCtrl_i (
        .clk        (clk),
        .rst        (rst),
        .press      (press),
        .timerIrq   (timerIrq),
        .enWr       (enWr),
        .pendClr    (pendClr),
        .wrData     (wrData),
        .irqEnable  (irqEnable),
        .irqPending (irqPending),
        .claimId    (claimId),
        .irq        (irq)
    );

    busDecoder decoder_i (
        .clk        (clk),
        .rst        (rst),
        .accEn      (accEn),
        .accWe      (accWe),
        .accAddr    (accAddr),
        .accWdata   (accWdata),
        .mtime      (mtime),
        .mtimeCmp   (mtimeCmp),
        .irqEnable  (irqEnable),
        .irqPending (irqPending),
        .claimId    (claimId),
        .timerWrLo  (timerWrLo),
        .timerWrHi  (timerWrHi),
        .enWr       (enWr),
        .pendClr    (pendClr),
        .wrData     (wrData),
        .rdValid    (rdValid),
        .rdData     (rdData)
    );

endmodule

// ==== logic/interruptCtrl.sv ====
// ====================================================================
// Interrupt controller.
// Latches the button, mirrors the timer, masks both with the enable
// register and ranks them into a claim identifier.
// ====================================================================

`timescale 1ns/100ps

module interruptCtrl import platformPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   press,                           // Debounced button strobe.
    input  logic   timerIrq,                        // Timer level.
    input  logic   enWr,                            // Write to the enable register.
    input  logic   pendClr,                         // Write to the pending register.
    input  dataT   wrData,
    output irqVecT irqEnable,
    output irqVecT irqPending,
    output irqIdT  claimId,
    output logic   irq                              // Request level to the core.
);

    irqVecT irqActive;                              // Sources both pending and enabled.

    // ====================================================================
    // Enable and pending registers
    // ====================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            irqEnable  <= '0;
            irqPending <= '0;
        end else begin
            if (enWr) begin
                irqEnable <= wrData[1:0];
            end
            irqPending[SRC_TIMER] <= timerIrq;      // Not clearable by software.
            if (press) begin
                irqPending[SRC_BUTTON] <= 1'b1;     // A set beats a clear.
            end else if (pendClr && wrData[SRC_BUTTON]) begin
                irqPending[SRC_BUTTON] <= 1'b0;
            end
        end
    end

    // ====================================================================
    // Masking and priority
    // ====================================================================
    assign irqActive = irqPending & irqEnable;
    assign irq       = |irqActive;

    always_comb begin
        if (irqActive[SRC_BUTTON]) begin
            claimId = ID_BUTTON;                    // Lowest source number wins.
        end else if (irqActive[SRC_TIMER]) begin
            claimId = ID_TIMER;
        end else begin
            claimId = ID_NONE;
        end
    end

endmodule

// ==== logic/machineTimer.sv ====
// ====================================================================
// Machine timer.
// Free-running 64-bit time count, a 64-bit compare register written a
// half at a time, and the timer interrupt level.
// ====================================================================

`timescale 1ns/100ps

module machineTimer import platformPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic timerWrLo,                         // Write the low compare half.
    input  logic timerWrHi,                         // Write the high compare half.
    input  dataT wrData,
    output timeT mtime,
    output timeT mtimeCmp,
    output logic timerIrq
);

    // ====================================================================
    // Time counter
    // ====================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            mtime <= '0;
        end else begin
            mtime <= mtime + 1'b1;                  // One tick per clock cycle.
        end
    end

    // ====================================================================
    // Compare register
    // ====================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            mtimeCmp <= MTIMECMP_RESET;
        end else begin
            if (timerWrLo) begin
                mtimeCmp[31:0] <= wrData;           // Halves are written independently.
            end
            if (timerWrHi) begin
                mtimeCmp[63:32] <= wrData;
            end
        end
    end

    // Level stays high until the compare value moves past the count.
    assign timerIrq = (mtime >= mtimeCmp);

endmodule

// ==== logic/platformPkg.sv ====
// ====================================================================
// Platform package.
// Address map, bus widths, interrupt source numbering and the button
// filter length shared by the peripheral blocks.
// ====================================================================

package platformPkg;

    // ====================================================================
    // Widths
    // ====================================================================
    typedef logic [15:0] addrT;                     // Byte address of a bus access.
    typedef logic [31:0] dataT;                     // Bus data word.
    typedef logic [63:0] timeT;                     // Machine time and compare value.
    typedef logic [1:0]  irqVecT;                   // One bit per interrupt source.
    typedef logic [1:0]  irqIdT;                    // Claim identifier.

    // ====================================================================
    // Interrupt sources
    // ====================================================================
    localparam int SRC_BUTTON = 0;                  // Bit of the push button.
    localparam int SRC_TIMER  = 1;                  // Bit of the machine timer.

    localparam irqIdT ID_NONE   = 2'd0;             // Nothing pending and enabled.
    localparam irqIdT ID_BUTTON = 2'd1;
    localparam irqIdT ID_TIMER  = 2'd2;

    // ====================================================================
    // Address map
    // ====================================================================
    localparam addrT ADDR_MTIME_LO    = 16'h0000;
    localparam addrT ADDR_MTIME_HI    = 16'h0004;
    localparam addrT ADDR_MTIMECMP_LO = 16'h0008;
    localparam addrT ADDR_MTIMECMP_HI = 16'h000C;
    localparam addrT ADDR_IRQ_ENABLE  = 16'h0010;   // Read and write.
    localparam addrT ADDR_IRQ_PENDING = 16'h0014;   // Write one to clear the button bit.
    localparam addrT ADDR_IRQ_CLAIM   = 16'h0018;   // Read only.

    // ====================================================================
    // Timer and button
    // ====================================================================
    localparam timeT MTIMECMP_RESET = '1;           // Keeps the timer quiet after reset.

    localparam int DEBOUNCE_CYCLES = 16;            // Stable cycles before a change is taken.
    typedef logic [$clog2(DEBOUNCE_CYCLES)-1:0] debounceCntT;
    localparam debounceCntT DEBOUNCE_LAST = debounceCntT'(DEBOUNCE_CYCLES - 1);

endpackage

// ==== vlog.f ====
logic/platformPkg.sv
logic/buttonDebounce.sv
logic/machineTimer.sv
logic/interruptCtrl.sv
logic/busDecoder.sv
logic/fpgaPlatform.sv
dv/platformClkGen.sv
dv/interruptCtrl_asserts.sv
dv/platformTb.sv
